/* flist.f */
+incdir+source
source/erx_link_pkg.sv
source/erx_cfg_pkg.sv
source/erx_protocol.sv
source/erx_remap.sv
source/erx_mailbox.sv
source/erx_cfg.sv
source/erx_distributor.sv
source/erx_core.sv
verif/erx_checker.sv
verif/erx_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the erx_core testbench with Verilator, verdict from sim.log
rm -f sim.log
verilator --binary --timing -f flist.f --top-module erx_core_tb -o erx_sim &&
   ./obj_dir/erx_sim > sim.log 2>&1 || exit 1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || grep -q "Finished with no errors" sim.log

/* source/erx_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_macros.svh"

module erx_cfg import erx_link_pkg::*, erx_cfg_pkg::*; (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                cfg_access,
   input  emesh_packet_t                       cfg_packet,
   input  logic [31:0]                         mbox_head,
   input  logic [$clog2(`ERX_MBOX_DEPTH+1)-1:0] mbox_count,
   input  logic                                resp_taken,      // Distributor loaded rxrr
   output logic                                rx_enable,
   output logic                                remap_en,
   output logic [11:0]                         remap_sel,
   output logic [11:0]                         remap_pattern,
   output logic [39:0]                         idelay_value,
   output logic                                load_taps,
   output logic                                mbox_pop,
   output logic                                cfg_resp_access,
   output emesh_packet_t                       cfg_resp_packet,
   output logic                                cfg_wait
);

   cfg_reg_e      reg_idx;
   emesh_packet_t resp_next;
   logic [31:0]   rd_data;
   logic          hit;
   logic          wr_req;
   logic          rd_req;

   assign reg_idx  = cfg_reg_e'(cfg_packet.dstaddr.mmr.reg_idx);
   assign cfg_wait = cfg_resp_access & ~resp_taken; // Frees as the response leaves
   assign hit      = cfg_access & ~cfg_wait & (cfg_packet.dstaddr.mmr.region == REGION_MMR);
   assign wr_req   = hit & cfg_packet.write;
   assign rd_req   = hit & ~cfg_packet.write;
   assign mbox_pop = rd_req & (reg_idx == REG_MBOX); // Head goes out with this read

   always_comb begin
      case (reg_idx)
         REG_CFG:    rd_data = {30'd0, remap_en, rx_enable};
         REG_SEL:    rd_data = {20'd0, remap_sel};
         REG_PAT:    rd_data = {20'd0, remap_pattern};
         REG_IDLY0:  rd_data = idelay_value[31:0];
         REG_IDLY1:  rd_data = {24'd0, idelay_value[39:32]};
         REG_MBOX:   rd_data = mbox_head;
         REG_MBSTAT: rd_data = 32'(mbox_count);
         default:    rd_data = 32'd0;     // Unmapped reads as zero
      endcase
   end

   // Response goes back to the requester
   always_comb begin
      resp_next              = cfg_packet;
      resp_next.srcaddr      = cfg_packet.dstaddr.flat;
      resp_next.data         = rd_data;
      resp_next.dstaddr.flat = cfg_packet.srcaddr;
      resp_next.write        = 1'b1;
      resp_next.spare        = 1'b0;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_enable       <= 1'b0;
         remap_en        <= 1'b0;
         remap_sel       <= '0;
         remap_pattern   <= '0;
         idelay_value    <= '0;
         load_taps       <= 1'b0;
         cfg_resp_access <= 1'b0;
      end else begin
         load_taps <= wr_req & (reg_idx == REG_IDLY1); // Taps load with the top byte
         if (rd_req)
            cfg_resp_access <= 1'b1;
         else if (resp_taken)
            cfg_resp_access <= 1'b0;
         if (wr_req) begin
            case (reg_idx)
               REG_CFG: begin
                  rx_enable <= cfg_packet.data[0];
                  remap_en  <= cfg_packet.data[1];
               end
               REG_SEL:   remap_sel           <= cfg_packet.data[11:0];
               REG_PAT:   remap_pattern       <= cfg_packet.data[11:0];
               REG_IDLY0: idelay_value[31:0]  <= cfg_packet.data;
               REG_IDLY1: idelay_value[39:32] <= cfg_packet.data[7:0];
               default:   ;                       // Read-only or unmapped
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req)
         cfg_resp_packet <= resp_next;
   end

endmodule

`default_nettype wire

/* source/erx_cfg_pkg.sv */
`default_nettype none

`include "erx_macros.svh"

package erx_cfg_pkg;

   // Region codes in dstaddr[19:16]
   typedef enum logic [3:0] {
      REGION_MEM  = 4'd0,     // Plain memory traffic
      REGION_MMR  = 4'd4,     // Register space
      REGION_RESP = 4'd8      // Returning read data
   } region_e;

   // Register file word offsets
   typedef enum logic [7:0] {
      REG_CFG    = `ERX_REG_CFG,
      REG_SEL    = `ERX_REG_SEL,
      REG_PAT    = `ERX_REG_PAT,
      REG_IDLY0  = `ERX_REG_IDLY0,
      REG_IDLY1  = `ERX_REG_IDLY1,
      REG_MBOX   = `ERX_REG_MBOX,
      REG_MBSTAT = `ERX_REG_MBSTAT
   } cfg_reg_e;

endpackage

`default_nettype wire

/* source/erx_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_macros.svh"

module erx_core import erx_link_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               rx_access,
   input  logic               rx_burst,
   input  logic [`ERX_PW-1:0] rx_packet,
   output logic               rx_wr_wait,    // Also covers responses
   output logic               rx_rd_wait,
   output logic               rxwr_access,
   output logic [`ERX_PW-1:0] rxwr_packet,
   input  logic               rxwr_wait,
   output logic               rxrd_access,
   output logic [`ERX_PW-1:0] rxrd_packet,
   input  logic               rxrd_wait,
   output logic               rxrr_access,
   output logic [`ERX_PW-1:0] rxrr_packet,
   input  logic               rxrr_wait,
   input  logic               cfg_access,
   input  logic [`ERX_PW-1:0] cfg_packet,
   output logic               cfg_wait,
   output logic [39:0]        idelay_value,
   output logic               load_taps,
   output logic               mailbox_full,
   output logic               mailbox_not_empty
);

   logic                                 rx_enable;
   logic                                 pipe_stall;
   logic                                 prot_access;  // Protocol stage
   traffic_e                             prot_class;
   emesh_packet_t                        prot_packet;
   logic                                 mbox_wr;
   emesh_packet_t                        mbox_data;
   logic                                 remap_en;     // Remap controls
   logic [11:0]                          remap_sel;
   logic [11:0]                          remap_pattern;
   logic                                 remap_access; // Remap stage
   traffic_e                             remap_class;
   emesh_packet_t                        remap_packet;
   logic                                 mbox_pop;
   logic [31:0]                          mbox_head;
   logic [$clog2(`ERX_MBOX_DEPTH+1)-1:0] mbox_count;
   logic                                 cfg_resp_access;
   emesh_packet_t                        cfg_resp_packet;
   logic                                 resp_taken;

   erx_protocol erx_protocol_i (
      .rx_packet (rx_packet),          // Flat bus into packet view
      .*
   );

   erx_remap erx_remap_i (.*);

   erx_mailbox #(
      .DEPTH (`ERX_MBOX_DEPTH)
   ) erx_mailbox_i (.*);

   erx_cfg erx_cfg_i (
      .cfg_packet (cfg_packet),
      .*
   );

   erx_distributor erx_distributor_i (
      .rxwr_packet (rxwr_packet),      // Packet view out to flat buses
      .rxrd_packet (rxrd_packet),
      .rxrr_packet (rxrr_packet),
      .*
   );

endmodule

`default_nettype wire

/* source/erx_distributor.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_distributor import erx_link_pkg::*; (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          remap_access,
   input  traffic_e      remap_class,
   input  emesh_packet_t remap_packet,
   input  logic          cfg_resp_access,
   input  emesh_packet_t cfg_resp_packet,
   input  logic          rxwr_wait,
   input  logic          rxrd_wait,
   input  logic          rxrr_wait,
   output logic          rxwr_access,
   output emesh_packet_t rxwr_packet,
   output logic          rxrd_access,
   output emesh_packet_t rxrd_packet,
   output logic          rxrr_access,
   output emesh_packet_t rxrr_packet,
   output logic          resp_taken,
   output logic          pipe_stall,
   output logic          rx_wr_wait,
   output logic          rx_rd_wait
);

   logic wr_free;                      // Channel may change this cycle
   logic rd_free;
   logic rr_free;
   logic link_take;
   logic link_rr;

   assign wr_free = ~(rxwr_access & rxwr_wait);
   assign rd_free = ~(rxrd_access & rxrd_wait);
   assign rr_free = ~(rxrr_access & rxrr_wait);
   assign pipe_stall = ~(wr_free & rd_free & rr_free); // Any held item freezes the pipe

   assign link_take  = remap_access & ~pipe_stall;
   assign link_rr    = link_take & (remap_class == RR);
   assign resp_taken = cfg_resp_access & rr_free & ~link_rr; // Link RR goes first

   assign rx_wr_wait = pipe_stall | rxwr_wait | rxrr_wait;
   assign rx_rd_wait = pipe_stall | rxrd_wait;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxwr_access <= 1'b0;
         rxrd_access <= 1'b0;
         rxrr_access <= 1'b0;
      end else begin
         if (wr_free)
            rxwr_access <= link_take & (remap_class == WR);
         if (rd_free)
            rxrd_access <= link_take & (remap_class == RD);
         if (rr_free)
            rxrr_access <= link_rr | resp_taken;
      end
   end

   always_ff @(posedge clk) begin
      if (link_take && (remap_class == WR))
         rxwr_packet <= remap_packet;
      if (link_take && (remap_class == RD))
         rxrd_packet <= remap_packet;
      if (link_rr)
         rxrr_packet <= remap_packet;
      else if (resp_taken)
         rxrr_packet <= cfg_resp_packet;  // Config read data
   end

endmodule

`default_nettype wire

/* source/erx_link_pkg.sv */
`default_nettype none

package erx_link_pkg;

   // Register-space view of a destination address
   typedef struct packed {
      logic [11:0] chip_id;  // Target chip
      logic [3:0]  region;   // Memory, MMR or response space
      logic [7:0]  reg_idx;  // Word offset in MMR space
      logic [7:0]  byte_off; // Byte inside the word
   } dst_mmr_t;

   // Same 32-bit word, flat or decoded
   typedef union packed {
      logic [31:0] flat;     // Remap works here
      dst_mmr_t    mmr;      // Decode works here
   } dst_addr_u;

   typedef struct packed {
      logic [31:0] srcaddr;  // Return address for reads
      logic [31:0] data;
      dst_addr_u   dstaddr;
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;    // 0 is a read request
      logic        spare;
   } emesh_packet_t;         // 104 bits

   // Output channel a beat is headed for
   typedef enum logic [1:0] {
      WR = 2'd0,             // Write
      RD = 2'd1,             // Read request
      RR = 2'd2              // Read response
   } traffic_e;

endpackage

`default_nettype wire

/* source/erx_macros.svh */
`ifndef ERX_MACROS_SVH
`define ERX_MACROS_SVH

// Link packet geometry
`define ERX_PW 104         // Full emesh packet width
`define ERX_ID 12'h800     // Chip ID in dstaddr[31:20]

// Mailbox FIFO
`define ERX_MBOX_DEPTH 4   // Words held before writes drop

// Register word offsets, the reg index field of the MMR view
`define ERX_REG_CFG    8'h00 // rx_enable, remap_en
`define ERX_REG_SEL    8'h01 // Remap select mask
`define ERX_REG_PAT    8'h02 // Remap pattern
`define ERX_REG_IDLY0  8'h03 // Tap delays, low word
`define ERX_REG_IDLY1  8'h04 // Tap delays, top byte and load
`define ERX_REG_MBOX   8'h05 // Mailbox data, pops on read
`define ERX_REG_MBSTAT 8'h06 // Mailbox fill level

`endif

/* source/erx_mailbox.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_macros.svh"

module erx_mailbox import erx_link_pkg::*; #(
   parameter int DEPTH = `ERX_MBOX_DEPTH
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       mbox_wr,
   input  emesh_packet_t              mbox_data,
   input  logic                       mbox_pop,
   output logic [31:0]                mbox_head,   // Oldest word
   output logic [$clog2(DEPTH+1)-1:0] mbox_count,
   output logic                       mailbox_full,
   output logic                       mailbox_not_empty
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [31:0]   mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic          push;
   logic          pop;

   assign mailbox_full      = (mbox_count == CW'(DEPTH));
   assign mailbox_not_empty = (mbox_count != '0);
   assign push = mbox_wr & ~mailbox_full;       // Full drops the word
   assign pop  = mbox_pop & mailbox_not_empty;
   assign mbox_head = mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         mbox_count <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap at depth
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            mbox_count <= mbox_count + 1'b1;
         else if (pop && !push)
            mbox_count <= mbox_count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= mbox_data.data; // Only the data word is kept
   end

endmodule

`default_nettype wire

/* source/erx_protocol.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_macros.svh"

module erx_protocol import erx_link_pkg::*, erx_cfg_pkg::*; (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          rx_enable,    // Beats dropped while low
   input  logic          pipe_stall,
   input  logic          rx_access,
   input  logic          rx_burst,     // High on continuation beats
   input  emesh_packet_t rx_packet,
   output logic          prot_access,
   output traffic_e      prot_class,
   output emesh_packet_t prot_packet,
   output logic          mbox_wr,      // One pulse per mailbox write
   output emesh_packet_t mbox_data
);

   emesh_packet_t beat;                // Beat with burst address filled in
   traffic_e      beat_class;
   logic [31:0]   last_addr;           // Previous accepted dstaddr
   logic          accept;
   logic          mbox_hit;

   assign accept = rx_access & rx_enable & ~pipe_stall;

   always_comb begin
      beat = rx_packet;
      if (rx_burst)
         beat.dstaddr.flat = last_addr + 32'd8; // Next doubleword
   end

   always_comb begin
      if (!beat.write)
         beat_class = RD;
      else if (beat.dstaddr.mmr.region == REGION_RESP)
         beat_class = RR;
      else
         beat_class = WR;
   end

   // Own mailbox register, kept out of the output stream
   assign mbox_hit = (beat_class == WR) &
                     (beat.dstaddr.mmr.chip_id == `ERX_ID) &
                     (beat.dstaddr.mmr.region == REGION_MMR) &
                     (beat.dstaddr.mmr.reg_idx == `ERX_REG_MBOX);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prot_access <= 1'b0;
         prot_class  <= WR;
         mbox_wr     <= 1'b0;
      end else begin
         mbox_wr <= accept & mbox_hit; // Never repeats during a stall
         if (!pipe_stall) begin
            prot_access <= accept & ~mbox_hit;
            prot_class  <= beat_class;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         prot_packet <= beat;
         last_addr   <= beat.dstaddr.flat;
      end
   end

   assign mbox_data = prot_packet;     // Valid while mbox_wr is high

endmodule

`default_nettype wire

/* source/erx_remap.sv */
`timescale 1ns/1ps
`default_nettype none

module erx_remap import erx_link_pkg::*; (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          pipe_stall,
   input  logic          remap_en,
   input  logic [11:0]   remap_sel,     // Bits taken from the pattern
   input  logic [11:0]   remap_pattern,
   input  logic          prot_access,
   input  traffic_e      prot_class,
   input  emesh_packet_t prot_packet,
   output logic          remap_access,
   output traffic_e      remap_class,
   output emesh_packet_t remap_packet
);

   emesh_packet_t remapped;

   always_comb begin
      remapped = prot_packet;
      if (remap_en && (prot_class != RR)) // Responses keep their address
         remapped.dstaddr.flat[31:20] = (prot_packet.dstaddr.flat[31:20] & ~remap_sel) |
                                        (remap_pattern & remap_sel);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         remap_access <= 1'b0;
         remap_class  <= WR;
      end else if (!pipe_stall) begin
         remap_access <= prot_access;
         remap_class  <= prot_class;
      end
   end

   always_ff @(posedge clk) begin
      if (!pipe_stall)
         remap_packet <= remapped;     // Holds its beat while stalled
   end

endmodule

`default_nettype wire

/* verif/erx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_macros.svh"

module erx_checker (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               rxwr_access,
   input  logic [`ERX_PW-1:0] rxwr_packet,
   input  logic               rxwr_wait,
   input  logic               rxrd_access,
   input  logic [`ERX_PW-1:0] rxrd_packet,
   input  logic               rxrd_wait,
   input  logic               rxrr_access,
   input  logic [`ERX_PW-1:0] rxrr_packet,
   input  logic               rxrr_wait,
   input  logic               rx_wr_wait,
   input  logic               rx_rd_wait,
   input  logic               cfg_wait,
   input  logic [39:0]        idelay_value,
   input  logic               load_taps,
   input  logic               mailbox_full,
   input  logic               mailbox_not_empty,
   input  logic               exp_push,      // One expected item per strobe
   input  logic [2:0]         exp_ch,        // 1 rxwr, 2 rxrd, 3 rxrr, 4 status
   input  logic [63:0]        exp_name,
   input  logic [`ERX_PW-1:0] exp_pkt,
   input  logic               final_chk,
   output int                 errors,
   output int                 pending        // Items still owed by the DUT
);

   logic [`ERX_PW+63:0] wr_q[$];             // Name over packet in arrival order
   logic [`ERX_PW+63:0] rd_q[$];
   logic [`ERX_PW+63:0] rr_q[$];
   logic [`ERX_PW+63:0] item;                // Oldest expectation of a channel
   logic [`ERX_PW-1:0]  status;
   logic [3:0]          taps_cnt;            // load_taps pulses so far
   logic                started;

   // Status word in the packet layout of the stim file
   assign status = {idelay_value[31:0], 18'd0, mailbox_full, mailbox_not_empty,
                    taps_cnt, idelay_value[39:32], 32'd0, 8'd0};

   task automatic compare(input logic [63:0] name, input logic [`ERX_PW-1:0] exp_v,
                          input logic [`ERX_PW-1:0] act);
      if (act !== exp_v) begin
         errors++;
         $display("FAILED %0s: expected %h actual %h", name, exp_v, act);
      end
   endtask

   task automatic stray(input string chan, input logic [`ERX_PW-1:0] act);
      errors++;
      $display("Unexpected packet %h on %s", act, chan);
   endtask

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         errors   = 0;
         taps_cnt <= 4'd0;
         started  <= 1'b0;
      end else begin
         if (!started) begin                 // First edge out of reset
            started <= 1'b1;
            if (rxwr_access | rxrd_access | rxrr_access | load_taps |
                rx_wr_wait | rx_rd_wait | cfg_wait) begin
               errors++;
               $display("Outputs or waits not idle after reset");
            end
         end
         if (load_taps)
            taps_cnt <= taps_cnt + 4'd1;
         if (rxwr_access && !rxwr_wait) begin
            if (wr_q.size() == 0)
               stray("rxwr", rxwr_packet);
            else begin
               item = wr_q.pop_front();
               compare(item[`ERX_PW+63:`ERX_PW], item[`ERX_PW-1:0], rxwr_packet);
            end
         end
         if (rxrd_access && !rxrd_wait) begin
            if (rd_q.size() == 0)
               stray("rxrd", rxrd_packet);
            else begin
               item = rd_q.pop_front();
               compare(item[`ERX_PW+63:`ERX_PW], item[`ERX_PW-1:0], rxrd_packet);
            end
         end
         if (rxrr_access && !rxrr_wait) begin
            if (rr_q.size() == 0)
               stray("rxrr", rxrr_packet);
            else begin
               item = rr_q.pop_front();
               compare(item[`ERX_PW+63:`ERX_PW], item[`ERX_PW-1:0], rxrr_packet);
            end
         end
         if (exp_push) begin
            case (exp_ch)
               3'd1:    wr_q.push_back({exp_name, exp_pkt});
               3'd2:    rd_q.push_back({exp_name, exp_pkt});
               3'd3:    rr_q.push_back({exp_name, exp_pkt});
               default: compare(exp_name, exp_pkt, status); // Immediate check
            endcase
         end
         pending = wr_q.size() + rd_q.size() + rr_q.size();
         if (final_chk && pending != 0) begin
            errors++;
            $display("%0d expected packets never came out", pending);
         end
      end
   end

endmodule

`default_nettype wire

/* verif/erx_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "erx_macros.svh"

module erx_core_tb;

   logic               clk;
   logic               rst_n;
   logic               rx_access;
   logic               rx_burst;
   logic [`ERX_PW-1:0] rx_packet;
   logic               rx_wr_wait;
   logic               rx_rd_wait;
   logic               rxwr_access;
   logic [`ERX_PW-1:0] rxwr_packet;
   logic               rxwr_wait;
   logic               rxrd_access;
   logic [`ERX_PW-1:0] rxrd_packet;
   logic               rxrd_wait;
   logic               rxrr_access;
   logic [`ERX_PW-1:0] rxrr_packet;
   logic               rxrr_wait;
   logic               cfg_access;
   logic [`ERX_PW-1:0] cfg_packet;
   logic               cfg_wait;
   logic [39:0]        idelay_value;
   logic               load_taps;
   logic               mailbox_full;
   logic               mailbox_not_empty;
   logic               exp_push;           // To the checker
   logic [2:0]         exp_ch;
   logic [63:0]        exp_name;
   logic [`ERX_PW-1:0] exp_pkt;
   logic               final_chk;
   int                 errors;
   int                 pending;
   int                 fails;              // Timeouts and file trouble
   int                 fd;
   int                 n;
   string              line;
   logic               rand_waits;         // Output waits from $urandom
   logic [63:0]        name;               // Current stim line fields
   logic [3:0]         kind;
   logic               burst;
   logic [31:0]        src;
   logic [31:0]        data;
   logic [31:0]        dst;
   logic [7:0]         ctl;
   logic [3:0]         ech;
   logic [31:0]        esrc;
   logic [31:0]        edata;
   logic [31:0]        edst;
   logic [7:0]         ectl;

   erx_core erx_core_i (.*);

   erx_checker checker_i (.*);

   always #50 clk = ~clk;

   task automatic timed_out(input string what);
      fails++;
      $display("Timeout while waiting for %s", what);
   endtask

   // Falling edge, strobes dropped, waits optionally reshuffled
   task automatic next_edge(input logic shuffle);
      @(negedge clk);
      rx_access  = 1'b0;
      rx_burst   = 1'b0;
      cfg_access = 1'b0;
      exp_push   = 1'b0;
      final_chk  = 1'b0;
      if (shuffle && rand_waits) begin
         rxwr_wait = ($urandom % 3) == 0;
         rxrd_wait = ($urandom % 3) == 0;
         rxrr_wait = ($urandom % 3) == 0;
      end
   endtask

   task automatic load_expect();
      exp_push = (ech != 4'd0);
      exp_ch   = ech[2:0];
      exp_name = name;
      exp_pkt  = {esrc, edata, edst, ectl};
   endtask

   task automatic send_link();
      int tries;
      tries = 0;
      do begin
         next_edge(1'b1);
         next_edge(1'b0);                  // Waits now steady until next fall
         tries++;
      end while ((ctl[1] ? rx_wr_wait : rx_rd_wait) && tries < 200);
      if (ctl[1] ? rx_wr_wait : rx_rd_wait)
         timed_out("the link wait to drop");
      else begin
         rx_access = 1'b1;
         rx_burst  = burst;
         rx_packet = {src, data, dst, ctl};
         load_expect();
      end
   endtask

   task automatic send_cfg();
      int tries;
      tries = 0;
      next_edge(1'b0);
      while (cfg_wait && tries < 200) begin
         next_edge(1'b0);
         tries++;
      end
      if (cfg_wait)
         timed_out("cfg_wait to drop");
      else begin
         cfg_access = 1'b1;
         cfg_packet = {src, data, dst, ctl};
         load_expect();
      end
   endtask

   task automatic drain();
      int tries;
      tries = 0;
      repeat (4) next_edge(1'b1);          // Let in-flight beats land
      while (pending != 0 && tries < 500) begin
         next_edge(1'b1);
         tries++;
      end
      if (pending != 0)
         timed_out("the output channels to drain");
   endtask

   task automatic run_line();
      case (kind)
         4'd0, 4'd1: send_cfg();
         4'd2:       send_link();
         4'd3: begin                       // Status snapshot
            drain();
            next_edge(1'b0);
            load_expect();
         end
         4'd4: begin
            next_edge(1'b0);
            rand_waits = data[0];
            rxwr_wait  = 1'b0;
            rxrd_wait  = 1'b0;
            rxrr_wait  = 1'b0;
         end
         default: begin
            fails++;
            $display("Unknown stimulus kind %0d", kind);
         end
      endcase
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      rx_access  = 1'b0;
      rx_burst   = 1'b0;
      rx_packet  = '0;
      rxwr_wait  = 1'b0;
      rxrd_wait  = 1'b0;
      rxrr_wait  = 1'b0;
      cfg_access = 1'b0;
      cfg_packet = '0;
      exp_push   = 1'b0;
      exp_ch     = 3'd0;
      exp_name   = '0;
      exp_pkt    = '0;
      final_chk  = 1'b0;
      rand_waits = 1'b0;
      fails      = 0;
      void'($urandom(32'h5d2c_c994));
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      fd = $fopen("verif/erx_stim.txt", "r");
      if (fd == 0) begin
         fails++;
         $display("Could not open verif/erx_stim.txt");
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.getc(0) != "/") begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, kind,
                           burst, src, data, dst, ctl, ech, esrc, edata, edst, ectl);
               if (n == 12)
                  run_line();
               else if (n > 0) begin
                  fails++;
                  $display("Malformed stim line: %s", line);
               end
            end
         end
         $fclose(fd);
      end
      drain();
      next_edge(1'b0);
      final_chk = 1'b1;                    // Leftover items count as lost
      next_edge(1'b0);
      next_edge(1'b0);
      $display("Checker errors %0d, other failures %0d", errors, fails);
      if (errors == 0 && fails == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/erx_stim.txt */
// name kind burst srcaddr data dstaddr ctl | exp_ch exp_srcaddr exp_data exp_dstaddr exp_ctl
// kind 0 cfg wr, 1 cfg rd, 2 link, 3 status, 4 rand waits; exp_ch 0 none 1 wr 2 rd 3 rr 4 status
reset  3 0 00000000 00000000 00000000 00 4 00000000 00000000 00000000 00
predis 2 0 00000011 DEAD0000 00001000 0A 0 00000000 00000000 00000000 00
enable 0 0 00000000 00000001 80040000 0A 0 00000000 00000000 00000000 00
wr     2 0 00000011 A5A50001 00002000 0A 1 00000011 A5A50001 00002000 0A
rd     2 0 00000022 00000000 00003000 08 2 00000022 00000000 00003000 08
rr     2 0 00000033 C0DE0003 00084000 0A 3 00000033 C0DE0003 00084000 0A
burst  2 0 00000040 B0000000 00005000 0A 1 00000040 B0000000 00005000 0A
burst  2 1 00000040 B0000001 00000000 0A 1 00000040 B0000001 00005008 0A
burst  2 1 00000040 B0000002 00000000 0A 1 00000040 B0000002 00005010 0A
remap  0 0 00000000 00000F00 80040100 0A 0 00000000 00000000 00000000 00
remap  0 0 00000000 00000300 80040200 0A 0 00000000 00000000 00000000 00
remap  0 0 00000000 00000003 80040000 0A 0 00000000 00000000 00000000 00
remap  2 0 00000050 12345678 12345678 0A 1 00000050 12345678 32345678 0A
remap  2 0 00000051 00000000 ABC00010 08 2 00000051 00000000 3BC00010 08
remap  2 0 00000052 FEED0052 FFF80020 0A 3 00000052 FEED0052 FFF80020 0A
remap  0 0 00000000 00000001 80040000 0A 0 00000000 00000000 00000000 00
mbox   2 0 00000060 11110001 80040500 0A 0 00000000 00000000 00000000 00
mbox   2 0 00000060 11110002 80040500 0A 0 00000000 00000000 00000000 00
mbox   2 0 00000060 11110003 80040500 0A 0 00000000 00000000 00000000 00
mbox   2 0 00000060 11110004 80040500 0A 0 00000000 00000000 00000000 00
mbox   2 0 00000060 11110005 80040500 0A 0 00000000 00000000 00000000 00
mbox   3 0 00000000 00000000 00000000 00 4 00000000 00003000 00000000 00
mbox   1 0 00000A00 00000000 80040500 08 3 80040500 11110001 00000A00 0A
mbox   1 0 00000A00 00000000 80040500 08 3 80040500 11110002 00000A00 0A
mbox   1 0 00000A00 00000000 80040500 08 3 80040500 11110003 00000A00 0A
mbox   1 0 00000A00 00000000 80040500 08 3 80040500 11110004 00000A00 0A
mbox   3 0 00000000 00000000 00000000 00 4 00000000 00000000 00000000 00
idelay 0 0 00000000 89ABCDEF 80040300 0A 0 00000000 00000000 00000000 00
idelay 0 0 00000000 00000042 80040400 0A 0 00000000 00000000 00000000 00
idelay 3 0 00000000 00000000 00000000 00 4 89ABCDEF 00000142 00000000 00
idelay 1 0 00000B00 00000000 80040300 08 3 80040300 89ABCDEF 00000B00 0A
idelay 1 0 00000B00 00000000 80040400 08 3 80040400 00000042 00000B00 0A
regs   1 0 00000B00 00000000 80040100 08 3 80040100 00000F00 00000B00 0A
regs   1 0 00000B00 00000000 80040000 08 3 80040000 00000001 00000B00 0A
prio   2 0 00000044 5EED0008 00080800 0A 3 00000044 5EED0008 00080800 0A
prio   1 0 00000C00 00000000 80040200 08 3 80040200 00000300 00000C00 0A
rand   4 0 00000000 00000001 00000000 00 0 00000000 00000000 00000000 00
rand   2 0 00000070 A0000001 00006000 0A 1 00000070 A0000001 00006000 0A
rand   2 0 00000071 00000000 00007000 08 2 00000071 00000000 00007000 08
rand   2 0 00000072 A0000003 00086000 0A 3 00000072 A0000003 00086000 0A
rand   2 0 00000073 A0000004 00006100 0A 1 00000073 A0000004 00006100 0A
rand   2 1 00000073 A0000005 00000000 0A 1 00000073 A0000005 00006108 0A
rand   2 0 00000074 00000000 00007100 08 2 00000074 00000000 00007100 08
rand   2 0 00000076 A0000009 00086100 0A 3 00000076 A0000009 00086100 0A
rand   2 0 00000077 A000000A 00006200 0A 1 00000077 A000000A 00006200 0A
rand   4 0 00000000 00000000 00000000 00 0 00000000 00000000 00000000 00
